//--- Makefile
SOURCES := $(filter-out +%,$(shell cat fp_unit.f)) hw/fp_defines.svh

.PHONY: run clean

run: obj_dir/Vtb_fp_unit
	./obj_dir/Vtb_fp_unit | tee sim.log
	grep -q "TESTS PASSED" sim.log

obj_dir/Vtb_fp_unit: fp_unit.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_fp_unit -Mdir obj_dir -f fp_unit.f

clean:
	rm -rf obj_dir sim.log

//--- fp_unit.f
+incdir+hw
hw/fp_pkg.sv
hw/fp_mul.sv
hw/fp_add.sv
hw/fp_int_to_float.sv
hw/fp_delay_line.sv
hw/fp_inv_sqrt.sv
hw/fp_unit.sv
test/tb_fp_unit.sv

//--- hw/fp_add.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module fp_add (
    input  logic          iCLK,
    input  logic          rst,
    input  logic          en,
    input  fp_pkg::fp27_t a,
    input  fp_pkg::fp27_t b,
    output fp_pkg::fp27_t sum
);
    localparam int MAN_W = `FP_FRAC_W + 1;
    // Carry bit, mantissa, guard bits for the shifted operand
    localparam int EXT_W = 2 * MAN_W;
    localparam int LZ_W  = $clog2(EXT_W + 1);

    // Stage one, align and add
    logic [MAN_W-1:0]     man_a;
    logic [MAN_W-1:0]     man_b;
    logic                 a_larger;
    logic [`FP_EXP_W-1:0] big_exp;
    logic [`FP_EXP_W-1:0] exp_diff;
    logic [EXT_W-1:0]     ext_big;
    logic [EXT_W-1:0]     ext_small;
    logic [EXT_W-1:0]     small_aligned;
    logic [EXT_W-1:0]     raw_sum;

    // Stage one registers
    logic [EXT_W-1:0]     s1_raw;
    logic [`FP_EXP_W-1:0] s1_exp;
    logic                 s1_sign;
    logic                 s1_a_zero;
    logic                 s1_b_zero;
    fp_pkg::fp27_t        s1_a;
    fp_pkg::fp27_t        s1_b;

    // Stage two, normalize
    logic [LZ_W-1:0]      lead;
    logic [EXT_W-1:0]     norm;
    logic [`FP_EXP_W+1:0] exp_wide;
    logic                 underflow;
    logic                 cancel;

    assign man_a = {1'b1, a.frac};
    assign man_b = {1'b1, b.frac};

    // Magnitude compare, ties go to b
    assign a_larger = (a.exp > b.exp) || ((a.exp == b.exp) && (a.frac > b.frac));
    assign big_exp  = a_larger ? a.exp : b.exp;
    assign exp_diff = a_larger ? a.exp - b.exp : b.exp - a.exp;

    assign ext_big   = {1'b0, (a_larger ? man_a : man_b), {`FP_FRAC_W{1'b0}}};
    assign ext_small = {1'b0, (a_larger ? man_b : man_a), {`FP_FRAC_W{1'b0}}};

    // Shift out of range leaves nothing
    assign small_aligned = (exp_diff >= `FP_EXP_W'(EXT_W)) ? '0 : ext_small >> exp_diff;

    // Opposite signs subtract small from big
    assign raw_sum = (a.sign ^ b.sign) ? ext_big - small_aligned
                                       : ext_big + small_aligned;

    always_ff @(posedge iCLK) begin
        if (rst) begin
            // Both flags set so the output settles to zero
            s1_a_zero <= 1'b1;
            s1_b_zero <= 1'b1;
        end else if (en) begin
            s1_a_zero <= (a.exp == '0);
            s1_b_zero <= (b.exp == '0);
        end
    end

    always_ff @(posedge iCLK) begin
        if (en) begin
            s1_raw  <= raw_sum;
            s1_exp  <= big_exp;
            s1_sign <= a_larger ? a.sign : b.sign;
            s1_a    <= a;
            s1_b    <= b;
        end
    end

    // Leading zero count, highest set bit wins
    always_comb begin
        lead = LZ_W'(EXT_W);
        for (int i = 0; i < EXT_W; i++) begin
            if (s1_raw[i]) begin
                lead = LZ_W'(EXT_W - 1 - i);
            end
        end
    end

    // Leading one moves to the top bit
    assign norm = s1_raw << lead;

    // Carry position is one above the hidden one
    assign exp_wide = (`FP_EXP_W+2)'(s1_exp) + (`FP_EXP_W+2)'(1)
                    - (`FP_EXP_W+2)'(lead);
    assign underflow = exp_wide[`FP_EXP_W+1] || (exp_wide == '0);
    assign cancel    = (s1_raw == '0);

    always_ff @(posedge iCLK) begin
        if (en) begin
            if (s1_a_zero && s1_b_zero) begin
                sum <= '0;
            end else if (s1_a_zero) begin
                sum <= s1_b;
            end else if (s1_b_zero) begin
                sum <= s1_a;
            end else if (cancel || underflow) begin
                sum <= '0;
            end else begin
                sum <= '{sign: s1_sign,
                         exp:  exp_wide[`FP_EXP_W-1:0],
                         frac: norm[EXT_W-2 -: `FP_FRAC_W]};
            end
        end
    end

endmodule

//--- hw/fp_defines.svh
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Word layout of the 27-bit float
// Sign on top, then exponent, then fraction
`define FP_WIDTH 27
`define FP_EXP_W 8
`define FP_FRAC_W 18

// Exponent code of the value one
`define FP_EXP_BIAS 127

// Integer width seen by the converter
`define FP_INT_W 16

// First guess constant for the inverse square root
`define FP_ISQRT_MAGIC 49920718

// Encoded 1.5 for the Newton step
`define FP_THREE_HALVES 33423360

// Cycles from accept to out_valid
// Output register counts as the last one
`define FP_LATENCY 5

`endif

//--- hw/fp_delay_line.sv
`timescale 1ns/100ps

module fp_delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     iCLK,
    input  logic     rst,
    input  logic     en,
    input  payload_t d,
    output payload_t q
);
    payload_t stage [DEPTH];

    always_ff @(posedge iCLK) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= payload_t'(0);
            end
        end else if (en) begin
            // Shift toward the output end
            for (int i = DEPTH - 1; i > 0; i--) begin
                stage[i] <= stage[i-1];
            end
            stage[0] <= d;
        end
    end

    assign q = stage[DEPTH-1];

endmodule

//--- hw/fp_int_to_float.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module fp_int_to_float (
    input  logic signed [`FP_INT_W-1:0] value,
    output fp_pkg::fp27_t               result
);
    localparam int POS_W = $clog2(`FP_INT_W);
    // Room to park any bit just above the fraction
    localparam int SH_W  = `FP_FRAC_W + `FP_INT_W;

    logic                 neg;
    logic [`FP_INT_W-1:0] mag;
    logic [POS_W-1:0]     top;
    logic [SH_W-1:0]      aligned;

    assign neg = value[`FP_INT_W-1];
    // Most negative value still fits as unsigned
    assign mag = neg ? `FP_INT_W'(-value) : `FP_INT_W'(value);

    // Position of the highest set bit
    always_comb begin
        top = '0;
        for (int i = 0; i < `FP_INT_W; i++) begin
            if (mag[i]) begin
                top = POS_W'(i);
            end
        end
    end

    // Leading one lands just above the fraction field
    assign aligned = {{`FP_FRAC_W{1'b0}}, mag} << (`FP_FRAC_W - top);

    always_comb begin
        if (mag == '0) begin
            result = '0;
        end else begin
            result.sign = neg;
            result.exp  = `FP_EXP_W'(`FP_EXP_BIAS) + `FP_EXP_W'(top);
            // Bits below the leading one, left aligned
            result.frac = aligned[`FP_FRAC_W-1:0];
        end
    end

endmodule

//--- hw/fp_inv_sqrt.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module fp_inv_sqrt (
    input  logic          iCLK,
    input  logic          rst,
    input  logic          en,
    input  fp_pkg::fp27_t a,
    output fp_pkg::fp27_t result
);
    // Guess waits for the two stages plus the adder
    localparam int GUESS_DEPTH = `FP_LATENCY - 1;

    logic [`FP_WIDTH-1:0] a_bits;
    fp_pkg::fp27_t        guess;
    fp_pkg::fp27_t        half_a;
    fp_pkg::fp27_t        guess_sq;
    fp_pkg::fp27_t        half_a_1;
    fp_pkg::fp27_t        guess_sq_1;
    fp_pkg::fp27_t        prod;
    fp_pkg::fp27_t        prod_2;
    fp_pkg::fp27_t        neg_prod;
    fp_pkg::fp27_t        three_halves;
    fp_pkg::fp27_t        correction;
    fp_pkg::fp27_t        guess_d;

    // Stage one
    assign a_bits = a;
    // Magic constant minus the word halved as an integer
    assign guess = fp_pkg::fp27_t'(`FP_WIDTH'(`FP_ISQRT_MAGIC) - (a_bits >> 1));
    // Halve by one step of exponent
    assign half_a = '{sign: a.sign, exp: a.exp - 1'b1, frac: a.frac};

    // y * y
    fp_mul u_square (
        .a    (guess),
        .b    (guess),
        .prod (guess_sq)
    );

    // Guess kept aside until the correction is ready
    // First stage of this line is the stage one guess register
    fp_delay_line #(
        .payload_t (fp_pkg::fp27_t),
        .DEPTH     (GUESS_DEPTH)
    ) u_guess_dly (
        .iCLK (iCLK),
        .rst  (1'b0),
        .en   (en),
        .d    (guess),
        .q    (guess_d)
    );

    // Stage two, x/2 * y * y
    fp_mul u_half_mul (
        .a    (half_a_1),
        .b    (guess_sq_1),
        .prod (prod)
    );

    always_ff @(posedge iCLK) begin
        if (en) begin
            half_a_1   <= half_a;
            guess_sq_1 <= guess_sq;
            prod_2     <= prod;
        end
    end

    // 1.5 - x/2 * y * y, subtract by flipping the sign
    assign neg_prod     = '{sign: ~prod_2.sign, exp: prod_2.exp, frac: prod_2.frac};
    assign three_halves = fp_pkg::fp27_t'(`FP_WIDTH'(`FP_THREE_HALVES));

    // Two cycles in here
    fp_add u_correct (
        .iCLK (iCLK),
        .rst  (rst),
        .en   (en),
        .a    (neg_prod),
        .b    (three_halves),
        .sum  (correction)
    );

    // Newton step result, combinational
    fp_mul u_final (
        .a    (guess_d),
        .b    (correction),
        .prod (result)
    );

endmodule

//--- hw/fp_mul.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module fp_mul (
    input  fp_pkg::fp27_t a,
    input  fp_pkg::fp27_t b,
    output fp_pkg::fp27_t prod
);
    // Mantissa with the hidden one
    localparam int MAN_W = `FP_FRAC_W + 1;
    // Full product width
    localparam int PROD_W = 2 * MAN_W;

    logic [MAN_W-1:0]      man_a;
    logic [MAN_W-1:0]      man_b;
    logic [PROD_W-1:0]     man_prod;
    logic                  carry;
    logic [`FP_EXP_W+1:0]  exp_sum;
    logic [`FP_FRAC_W-1:0] frac_out;
    logic                  underflow;
    logic                  any_zero;

    // Restore hidden ones
    assign man_a = {1'b1, a.frac};
    assign man_b = {1'b1, b.frac};

    // Product lies in [1, 4)
    assign man_prod = man_a * man_b;
    // Top bit set when product reached two
    assign carry = man_prod[PROD_W-1];

    // Biased exponent sum, one extra on carry
    assign exp_sum = (`FP_EXP_W+2)'(a.exp) + (`FP_EXP_W+2)'(b.exp)
                   + (`FP_EXP_W+2)'(carry);

    // Drop the leading one and keep the next bits
    assign frac_out = carry ? man_prod[PROD_W-2 -: `FP_FRAC_W]
                            : man_prod[PROD_W-3 -: `FP_FRAC_W];

    // Result exponent would be zero or below
    assign underflow = exp_sum <= (`FP_EXP_W+2)'(`FP_EXP_BIAS);
    // Zero operands are not really 1.x
    assign any_zero = (a.exp == '0) || (b.exp == '0);

    always_comb begin
        if (underflow || any_zero) begin
            prod = '0;
        end else begin
            prod.sign = a.sign ^ b.sign;
            // Remove one bias
            prod.exp  = `FP_EXP_W'(exp_sum - (`FP_EXP_W+2)'(`FP_EXP_BIAS));
            prod.frac = frac_out;
        end
    end

endmodule

//--- hw/fp_pkg.sv
`include "fp_defines.svh"

package fp_pkg;

    // Float word as carried on every internal path
    // Zero is written with exponent zero
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp27_t;

    // Operation select
    typedef enum logic [1:0] {
        // Two operand sum
        OP_ADD   = 2'd0,
        // Two operand product
        OP_MUL   = 2'd1,
        // Inverse square root of operand a
        OP_ISQRT = 2'd2,
        // Signed integer to float
        OP_ITOF  = 2'd3
    } fp_op_e;

endpackage

//--- hw/fp_unit.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module fp_unit (
    input  logic                        iCLK,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  fp_pkg::fp_op_e              in_op,
    input  logic [`FP_WIDTH-1:0]        in_a,
    input  logic [`FP_WIDTH-1:0]        in_b,
    input  logic signed [`FP_INT_W-1:0] in_int,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`FP_WIDTH-1:0]        out_result
);
    // Every path meets here, one cycle before the output register
    localparam int ALIGN_DEPTH = `FP_LATENCY - 1;
    // Adder takes two of those cycles itself
    localparam int ADD_PAD     = ALIGN_DEPTH - 2;

    logic           advance;
    logic           accept;
    logic           valid_d;
    fp_pkg::fp_op_e op_d;
    fp_pkg::fp27_t  opa;
    fp_pkg::fp27_t  opb;
    fp_pkg::fp27_t  add_sum;
    fp_pkg::fp27_t  add_d;
    fp_pkg::fp27_t  mul_prod;
    fp_pkg::fp27_t  itof_res;
    fp_pkg::fp27_t  early_res;
    fp_pkg::fp27_t  early_d;
    fp_pkg::fp27_t  isqrt_res;
    fp_pkg::fp27_t  selected;

    // Pipeline moves when the output slot is free or being taken
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;
    assign accept   = in_valid && advance;

    assign opa = in_a;
    assign opb = in_b;

    // Valid bits, cleared on reset
    fp_delay_line #(
        .payload_t (logic),
        .DEPTH     (ALIGN_DEPTH)
    ) u_valid_dly (
        .iCLK (iCLK),
        .rst  (rst),
        .en   (advance),
        .d    (accept),
        .q    (valid_d)
    );

    // Operation code follows its request
    fp_delay_line #(
        .payload_t (fp_pkg::fp_op_e),
        .DEPTH     (ALIGN_DEPTH)
    ) u_op_dly (
        .iCLK (iCLK),
        .rst  (1'b0),
        .en   (advance),
        .d    (in_op),
        .q    (op_d)
    );

    // Add path
    fp_add u_add (
        .iCLK (iCLK),
        .rst  (rst),
        .en   (advance),
        .a    (opa),
        .b    (opb),
        .sum  (add_sum)
    );

    fp_delay_line #(
        .payload_t (fp_pkg::fp27_t),
        .DEPTH     (ADD_PAD)
    ) u_add_dly (
        .iCLK (iCLK),
        .rst  (1'b0),
        .en   (advance),
        .d    (add_sum),
        .q    (add_d)
    );

    // Multiply and convert finish at once, so they share one line
    fp_mul u_mul (
        .a    (opa),
        .b    (opb),
        .prod (mul_prod)
    );

    fp_int_to_float u_itof (
        .value  (in_int),
        .result (itof_res)
    );

    assign early_res = (in_op == fp_pkg::OP_ITOF) ? itof_res : mul_prod;

    fp_delay_line #(
        .payload_t (fp_pkg::fp27_t),
        .DEPTH     (ALIGN_DEPTH)
    ) u_early_dly (
        .iCLK (iCLK),
        .rst  (1'b0),
        .en   (advance),
        .d    (early_res),
        .q    (early_d)
    );

    // Already four cycles deep
    fp_inv_sqrt u_isqrt (
        .iCLK   (iCLK),
        .rst    (rst),
        .en     (advance),
        .a      (opa),
        .result (isqrt_res)
    );

    // Pick by the delayed op
    always_comb begin
        case (op_d)
            fp_pkg::OP_ADD:   selected = add_d;
            fp_pkg::OP_ISQRT: selected = isqrt_res;
            default:          selected = early_d;
        endcase
    end

    // Output register, holds under stall
    always_ff @(posedge iCLK) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= valid_d;
        end
    end

    always_ff @(posedge iCLK) begin
        if (advance) begin
            out_result <= selected;
        end
    end

endmodule

//--- test/tb_fp_unit.sv
`timescale 1ns/100ps
`include "fp_defines.svh"

module tb_fp_unit;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    // Cycles allowed per request, room for random stalls
    localparam int STALL_MARGIN = 8;
    // First pass at full rate, second one with random gaps
    localparam int PASSES       = 2;
    localparam int SEED         = 32'h42c21b74;

    typedef struct packed {
        fp_pkg::fp_op_e              op;
        logic [`FP_WIDTH-1:0]        a;
        logic [`FP_WIDTH-1:0]        b;
        logic signed [`FP_INT_W-1:0] ival;
        logic [`FP_WIDTH-1:0]        want;
        // Checked against a tolerance, not a word
        logic                        approx;
    } test_case_t;

    logic                        iCLK;
    logic                        rst;
    logic                        in_valid;
    logic                        in_ready;
    fp_pkg::fp_op_e              in_op;
    logic [`FP_WIDTH-1:0]        in_a;
    logic [`FP_WIDTH-1:0]        in_b;
    logic signed [`FP_INT_W-1:0] in_int;
    logic                        out_valid;
    logic                        out_ready;
    logic [`FP_WIDTH-1:0]        out_result;

    test_case_t cases[$];
    // Table indices of accepted requests, oldest first
    int         pending_q[$];
    bit         table_ready;
    int         issued;
    int         received;
    int         total;

    fp_unit DUT (
        .iCLK       (iCLK),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_int     (in_int),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        iCLK = 1'b0;
        forever #(CLK_PERIOD/2) iCLK = ~iCLK;
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    // Real to word, only for values the format holds exactly
    function automatic logic [`FP_WIDTH-1:0] encode(input real v);
        logic sign;
        real  m;
        int   e;
        int   frac;
        if (v == 0.0) begin
            return '0;
        end
        sign = (v < 0.0);
        m = sign ? -v : v;
        e = 0;
        // Bring the mantissa into [1, 2)
        while (m >= 2.0) begin
            m = m / 2.0;
            e++;
        end
        while (m < 1.0) begin
            m = m * 2.0;
            e--;
        end
        frac = $rtoi((m - 1.0) * 262144.0);
        return {sign, `FP_EXP_W'(e + `FP_EXP_BIAS), `FP_FRAC_W'(frac)};
    endfunction

    // Word to real by the format rule
    function automatic real decode(input logic [`FP_WIDTH-1:0] w);
        fp_pkg::fp27_t f;
        real           v;
        int            e;
        f = w;
        if (f.exp == '0) begin
            return 0.0;
        end
        v = 1.0 + real'(f.frac) / 262144.0;
        e = int'(f.exp) - `FP_EXP_BIAS;
        for (int i = 0; i < e; i++) v = v * 2.0;
        for (int i = 0; i > e; i--) v = v / 2.0;
        return f.sign ? -v : v;
    endfunction

    task automatic add_case(input fp_pkg::fp_op_e op, input logic [`FP_WIDTH-1:0] a,
                            input logic [`FP_WIDTH-1:0] b, input int ival,
                            input logic [`FP_WIDTH-1:0] want, input logic approx);
        test_case_t c;
        c.op     = op;
        c.a      = a;
        c.b      = b;
        c.ival   = `FP_INT_W'(ival);
        c.want   = want;
        c.approx = approx;
        cases.push_back(c);
    endtask

    task automatic build_table();
        // Integer conversion
        add_case(fp_pkg::OP_ITOF, '0, '0, 0, '0, 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, 1, encode(1.0), 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, -1, encode(-1.0), 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, 3, encode(3.0), 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, 1000, encode(1000.0), 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, 32767, encode(32767.0), 1'b0);
        add_case(fp_pkg::OP_ITOF, '0, '0, -32768, encode(-32768.0), 1'b0);
        // Products with short mantissas
        add_case(fp_pkg::OP_MUL, encode(1.5), encode(-2.0), 0, encode(-3.0), 1'b0);
        add_case(fp_pkg::OP_MUL, encode(3.0), encode(0.25), 0, encode(0.75), 1'b0);
        add_case(fp_pkg::OP_MUL, encode(-1.25), encode(-4.0), 0, encode(5.0), 1'b0);
        add_case(fp_pkg::OP_MUL, '0, encode(5.0), 0, '0, 1'b0);
        add_case(fp_pkg::OP_MUL, encode(2.5), '0, 0, '0, 1'b0);
        // Sums, zero passthrough and cancellation
        add_case(fp_pkg::OP_ADD, encode(1.0), encode(2.0), 0, encode(3.0), 1'b0);
        add_case(fp_pkg::OP_ADD, encode(3.0), encode(-1.5), 0, encode(1.5), 1'b0);
        add_case(fp_pkg::OP_ADD, '0, encode(5.0), 0, encode(5.0), 1'b0);
        add_case(fp_pkg::OP_ADD, encode(-2.5), '0, 0, encode(-2.5), 1'b0);
        add_case(fp_pkg::OP_ADD, encode(7.25), encode(-7.25), 0, '0, 1'b0);
        add_case(fp_pkg::OP_ADD, '0, '0, 0, '0, 1'b0);
        // Inverse square root, checked by tolerance
        add_case(fp_pkg::OP_ISQRT, encode(1.0), '0, 0, '0, 1'b1);
        add_case(fp_pkg::OP_ISQRT, encode(4.0), '0, 0, '0, 1'b1);
        add_case(fp_pkg::OP_ISQRT, encode(16.0), '0, 0, '0, 1'b1);
        add_case(fp_pkg::OP_ISQRT, encode(2.0), '0, 0, '0, 1'b1);
        add_case(fp_pkg::OP_ISQRT, encode(100.0), '0, 0, '0, 1'b1);
    endtask

    task automatic check_result();
        test_case_t c;
        real        r;
        real        prod;
        assert (pending_q.size() != 0) else
            report_failure("A result came out with no request outstanding");
        c = cases[pending_q.pop_front()];
        if (c.approx) begin
            r = decode(out_result);
            // y * y * x should be close to one
            prod = r * r * decode(c.a);
            assert (prod > 0.99 && prod < 1.01) else
                report_failure($sformatf("** Error: out_result = %h for input %h, y*y*x = %f",
                                         out_result, c.a, prod));
        end else begin
            assert (out_result === c.want) else
                report_failure($sformatf("** Error: out_result = %h, expected %h (op %0d)",
                                         out_result, c.want, c.op));
        end
        received++;
    endtask

    initial begin
        bit holding;
        bit random_mode;
        void'($urandom(SEED));
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = fp_pkg::OP_ADD;
        in_a      = '0;
        in_b      = '0;
        in_int    = '0;
        out_ready = 1'b0;
        issued    = 0;
        received  = 0;
        holding   = 1'b0;
        build_table();
        total       = PASSES * cases.size();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(negedge iCLK);
        rst = 1'b0;

        // Nothing accepted yet, nothing may come out
        repeat (3) begin
            @(negedge iCLK);
            #(CLK_PERIOD/4);
            assert (out_valid === 1'b0) else
                report_failure($sformatf("** Error: out_valid = %h after reset, expected 0",
                                         out_valid));
        end

        while (received < total) begin
            @(negedge iCLK);
            random_mode = (issued >= cases.size());
            // A request stays on the bus until it is taken
            if (!holding) begin
                if (issued < total && (!random_mode || ($urandom % 4) != 0)) begin
                    in_op    = cases[issued % cases.size()].op;
                    in_a     = cases[issued % cases.size()].a;
                    in_b     = cases[issued % cases.size()].b;
                    in_int   = cases[issued % cases.size()].ival;
                    in_valid = 1'b1;
                    holding  = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = random_mode ? (($urandom % 4) != 0) : 1'b1;
            // Handshakes settle well before the next rising edge
            #(CLK_PERIOD/4);
            if (out_valid && out_ready) begin
                check_result();
            end
            if (in_valid && in_ready) begin
                pending_q.push_back(issued % cases.size());
                issued++;
                holding = 1'b0;
            end
        end

        // No extra or repeated results after the last one
        @(negedge iCLK);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        repeat (2 * `FP_LATENCY) begin
            @(negedge iCLK);
            #(CLK_PERIOD/4);
            assert (out_valid === 1'b0) else
                report_failure("A result came out after every request was answered");
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + 16 + PASSES * cases.size() * `FP_LATENCY * STALL_MARGIN;
        repeat (limit) @(posedge iCLK);
        report_failure($sformatf("Timeout: only %0d of %0d results arrived in %0d cycles",
                                 received, total, limit));
    end

endmodule
